//--- pce_io_pkg.sv
package pce_io_pkg;

  // cartridge store geometry
  // byte addressed, 16 KiB
  localparam int ROM_ADDR_W = 14;

  // final load address bit that flags a 512-byte copier header
  localparam int HEADER_BIT = 9;

  // address bit telling the two signature windows apart
  localparam int BANK_BIT = 13;

  typedef logic [ROM_ADDR_W-1:0] rom_addr_t;

  // one download beat from the host
  typedef logic [15:0] rom_word_t;

  // byte as seen on the rom read side
  typedef logic [7:0] rom_byte_t;

  // read offset past the header
  localparam rom_addr_t HEADER_OFFSET = 14'd512;

  // signature windows
  // plain image and headered image
  localparam rom_addr_t SIG_BASE_PLAIN = 14'h1F20;
  localparam rom_addr_t SIG_BASE_HDR = 14'h2120;

  // expected words at window offsets 6, 8, 10 and 12
  localparam rom_word_t SIG_WORD_0 = 16'h4F50;
  localparam rom_word_t SIG_WORD_1 = 16'h5550;
  localparam rom_word_t SIG_WORD_2 = 16'h4F4C;
  localparam rom_word_t SIG_WORD_3 = 16'h5355;

  // controller port nibble, active low
  typedef logic [3:0] pad_nibble_t;

  // multitap port number
  // 0 is the only populated port
  typedef logic [2:0] pad_port_t;

  // released pad, every line high
  localparam pad_nibble_t NIBBLE_IDLE_PORT = 4'hF;

  // six-button identity page
  localparam pad_nibble_t NIBBLE_ID = 4'h0;

  // download sequencer states
  typedef enum logic [2:0] {
    // no cartridge download running
    IDLE,
    // waiting for the next ioctl_wr rising edge
    WAIT_EDGE,
    // write request out to the rom store
    REQ,
    // ack seen, req dropped, waiting for ack to clear
    WAIT_ACK_LOW,
    // handshake done, waiting for host to release ioctl_wr
    WAIT_FALL
  } load_state_t;

endpackage

//--- cart_load_fsm.sv
`timescale 1ns/1ps

module cart_load_fsm (
  input  logic                  clk_sys_42_95,
  input  logic                  arst_n,
  input  logic                  cart_download,
  input  logic                  ioctl_wr,
  input  pce_io_pkg::rom_word_t ioctl_dout,
  input  logic                  bit_reverse,
  output logic                  ioctl_wait,
  output logic                  mem_req,
  input  logic                  mem_ack,
  output pce_io_pkg::rom_addr_t mem_addr,
  output pce_io_pkg::rom_word_t mem_data,
  output pce_io_pkg::rom_addr_t load_addr,
  output logic                  load_start,
  output logic                  word_strobe
);

  pce_io_pkg::load_state_t state;
  pce_io_pkg::rom_word_t   word_in;
  logic                    wr_q;
  logic                    wr_rise;
  logic                    take_word;

  assign wr_rise = ioctl_wr & ~wr_q;

  // a new beat is only accepted between handshakes
  // edges arriving while ioctl_wait is up are dropped
  assign take_word = (state == pce_io_pkg::WAIT_EDGE) && cart_download && wr_rise;

  // optional bit swap inside each byte
  // some dumps come mirrored
  always_comb begin
    word_in = ioctl_dout;
    if (bit_reverse) begin
      for (int i = 0; i < 8; i++) begin
        word_in[i]     = ioctl_dout[7-i];
        word_in[8 + i] = ioctl_dout[15-i];
      end
    end
  end

  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      state       <= pce_io_pkg::IDLE;
      wr_q        <= 1'b0;
      ioctl_wait  <= 1'b0;
      mem_req     <= 1'b0;
      load_addr   <= '0;
      load_start  <= 1'b0;
      word_strobe <= 1'b0;
    end else begin
      wr_q        <= ioctl_wr;
      load_start  <= 1'b0;
      word_strobe <= 1'b0;
      case (state)
        // leaving idle only on a fresh download, so this is the rising edge
        pce_io_pkg::IDLE: begin
          if (cart_download) begin
            load_addr  <= '0;
            load_start <= 1'b1;
            state      <= pce_io_pkg::WAIT_EDGE;
          end
        end
        pce_io_pkg::WAIT_EDGE: begin
          if (!cart_download) begin
            state <= pce_io_pkg::IDLE;
          end else if (take_word) begin
            ioctl_wait  <= 1'b1;
            word_strobe <= 1'b1;
            state       <= pce_io_pkg::REQ;
          end
        end
        // payload settles one cycle before req goes up
        pce_io_pkg::REQ: begin
          if (!mem_req) begin
            mem_req <= 1'b1;
          end else if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= pce_io_pkg::WAIT_ACK_LOW;
          end
        end
        pce_io_pkg::WAIT_ACK_LOW: begin
          if (!mem_ack) begin
            ioctl_wait <= 1'b0;
            state      <= pce_io_pkg::WAIT_FALL;
          end
        end
        // step on the falling edge of ioctl_wr
        pce_io_pkg::WAIT_FALL: begin
          if (!ioctl_wr) begin
            load_addr <= load_addr + pce_io_pkg::rom_addr_t'(2);
            state     <= pce_io_pkg::WAIT_EDGE;
          end
        end
        default: state <= pce_io_pkg::IDLE;
      endcase
    end
  end

  // write payload, captured with the beat
  always_ff @(posedge clk_sys_42_95) begin
    if (take_word) begin
      mem_data <= word_in;
      mem_addr <= load_addr;
    end
  end

  // rom store relies on a frozen payload for the whole request
  a_payload_stable: assert property (@(posedge clk_sys_42_95) disable iff (!arst_n)
    mem_req |=> !mem_req || ($stable(mem_addr) && $stable(mem_data)));

endmodule

//--- populous_detect.sv
`timescale 1ns/1ps

module populous_detect (
  input  logic                  clk_sys_42_95,
  input  logic                  arst_n,
  input  logic                  load_start,
  input  logic                  word_strobe,
  input  pce_io_pkg::rom_addr_t load_addr,
  input  pce_io_pkg::rom_word_t word,
  input  logic                  header_sel,
  output logic                  rom_populous
);

  // bit 0 plain window, bit 1 headered window
  logic [1:0]            pop_flag;
  logic                  in_window;
  logic                  sig_slot;
  pce_io_pkg::rom_word_t sig_expect;

  // 16-byte windows, compare above the low nibble
  assign in_window =
    (load_addr[pce_io_pkg::ROM_ADDR_W-1:4] == pce_io_pkg::SIG_BASE_PLAIN[pce_io_pkg::ROM_ADDR_W-1:4]) ||
    (load_addr[pce_io_pkg::ROM_ADDR_W-1:4] == pce_io_pkg::SIG_BASE_HDR[pce_io_pkg::ROM_ADDR_W-1:4]);

  // four signature slots inside the window
  always_comb begin
    sig_slot   = 1'b0;
    sig_expect = '0;
    case (load_addr[3:0])
      4'd6: begin
        sig_slot   = 1'b1;
        sig_expect = pce_io_pkg::SIG_WORD_0;
      end
      4'd8: begin
        sig_slot   = 1'b1;
        sig_expect = pce_io_pkg::SIG_WORD_1;
      end
      4'd10: begin
        sig_slot   = 1'b1;
        sig_expect = pce_io_pkg::SIG_WORD_2;
      end
      4'd12: begin
        sig_slot   = 1'b1;
        sig_expect = pce_io_pkg::SIG_WORD_3;
      end
      default: ;
    endcase
  end

  // both candidates assumed until a slot disagrees
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      pop_flag <= 2'b11;
    end else if (load_start) begin
      pop_flag <= 2'b11;
    end else if (word_strobe && in_window && sig_slot && (word != sig_expect)) begin
      pop_flag[load_addr[pce_io_pkg::BANK_BIT]] <= 1'b0;
    end
  end

  // header flag picks which window counts
  assign rom_populous = pop_flag[header_sel];

endmodule

//--- rom_store.sv
`timescale 1ns/1ps

module rom_store (
  input  logic                  clk_sys_42_95,
  input  logic                  arst_n,
  input  logic                  mem_req,
  output logic                  mem_ack,
  input  pce_io_pkg::rom_addr_t mem_addr,
  input  pce_io_pkg::rom_word_t mem_data,
  input  logic                  header_skip,
  input  pce_io_pkg::rom_addr_t rom_rd_addr,
  output pce_io_pkg::rom_byte_t rom_rd_data
);

  // word wide array, low byte sits at the even address
  pce_io_pkg::rom_word_t mem_w [2**(pce_io_pkg::ROM_ADDR_W-1)];
  pce_io_pkg::rom_addr_t rd_addr;
  pce_io_pkg::rom_word_t rd_word;
  logic                  wr_en;

  // first cycle of a request, ack not yet up
  assign wr_en = mem_req & ~mem_ack;

  // skip the copier header, wraps at 16 KiB
  assign rd_addr = rom_rd_addr +
    (header_skip ? pce_io_pkg::HEADER_OFFSET : pce_io_pkg::rom_addr_t'(0));

  assign rd_word = mem_w[rd_addr[pce_io_pkg::ROM_ADDR_W-1:1]];

  // four-phase responder
  // ack follows req both ways, one cycle behind
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      mem_ack <= 1'b0;
    end else if (wr_en) begin
      mem_ack <= 1'b1;
    end else if (!mem_req) begin
      mem_ack <= 1'b0;
    end
  end

  // storage and registered byte read
  always_ff @(posedge clk_sys_42_95) begin
    if (wr_en) begin
      mem_w[mem_addr[pce_io_pkg::ROM_ADDR_W-1:1]] <= mem_data;
    end
    rom_rd_data <= rd_addr[0] ? rd_word[15:8] : rd_word[7:0];
  end

  // ack only answers a live request from the loader
  a_ack_needs_req: assert property (@(posedge clk_sys_42_95) disable iff (!arst_n)
    $rose(mem_ack) |-> mem_req);

endmodule

//--- pad_port_scan.sv
`timescale 1ns/1ps

module pad_port_scan (
  input  logic                  clk_sys_42_95,
  input  logic                  arst_n,
  input  logic                  pad_clr,
  input  logic                  pad_sel,
  input  logic                  six_button,
  input  logic                  multitap,
  output pce_io_pkg::pad_port_t port,
  output logic                  page_high,
  output logic                  clr_active
);

  logic clr_q;
  logic sel_q;
  logic clr_rise;
  logic sel_rise;

  assign clr_rise = pad_clr & ~clr_q;
  assign sel_rise = pad_sel & ~sel_q;

  // clear level, the nibble register blanks on it directly
  assign clr_active = pad_clr;

  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      clr_q     <= 1'b0;
      sel_q     <= 1'b0;
      port      <= '0;
      page_high <= 1'b0;
    end else begin
      clr_q <= pad_clr;
      sel_q <= pad_sel;
      if (pad_clr) begin
        // clear pins the scan to the first port
        port <= '0;
        // six-button pads flip pages on every clear
        if (clr_rise) begin
          page_high <= six_button & ~page_high;
        end
      end else if (sel_rise && multitap) begin
        // tap steps through ports, 3 bit wrap
        port <= port + pce_io_pkg::pad_port_t'(1);
      end
    end
  end

  // two-button mode never lands on the high page
  a_page_low_2btn: assert property (@(posedge clk_sys_42_95) disable iff (!arst_n)
    !six_button && ($rose(pad_clr) || !page_high) |=> !page_high);

endmodule

//--- pad_nibble_mux.sv
`timescale 1ns/1ps

module pad_nibble_mux (
  input  logic                    clk_sys_42_95,
  input  logic                    arst_n,
  input  logic                    button_a,
  input  logic                    button_b,
  input  logic                    button_select,
  input  logic                    button_start,
  input  logic                    dpad_up,
  input  logic                    dpad_down,
  input  logic                    dpad_left,
  input  logic                    dpad_right,
  input  pce_io_pkg::pad_port_t   port,
  input  logic                    page_high,
  input  logic                    clr_active,
  input  logic                    pad_sel,
  output pce_io_pkg::pad_nibble_t pad_data
);

  pce_io_pkg::pad_nibble_t nibble;

  always_comb begin
    if (page_high) begin
      // extra buttons absent, then the id nibble
      nibble = pad_sel ? pce_io_pkg::NIBBLE_ID : pce_io_pkg::NIBBLE_IDLE_PORT;
    end else if (port != '0) begin
      // empty tap port, all released
      nibble = pce_io_pkg::NIBBLE_IDLE_PORT;
    end else if (pad_sel) begin
      // dpad half
      nibble = ~{dpad_left, dpad_down, dpad_right, dpad_up};
    end else begin
      // button half
      nibble = ~{button_start, button_select, button_b, button_a};
    end
  end

  // latched nibble, zero for the whole clear pulse
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      pad_data <= '0;
    end else if (clr_active) begin
      pad_data <= '0;
    end else begin
      pad_data <= nibble;
    end
  end

endmodule

//--- pce_io_top.sv
`timescale 1ns/1ps

module pce_io_top (
  input  logic                    clk_sys_42_95,
  input  logic                    arst_n,
  // cartridge download
  input  logic                    cart_download,
  input  logic                    ioctl_wr,
  input  pce_io_pkg::rom_word_t   ioctl_dout,
  input  logic                    bit_reverse,
  output logic                    ioctl_wait,
  // rom read side
  input  pce_io_pkg::rom_addr_t   rom_rd_addr,
  output pce_io_pkg::rom_byte_t   rom_rd_data,
  output logic                    rom_populous,
  // pad buttons
  input  logic                    button_a,
  input  logic                    button_b,
  input  logic                    button_select,
  input  logic                    button_start,
  input  logic                    dpad_up,
  input  logic                    dpad_down,
  input  logic                    dpad_left,
  input  logic                    dpad_right,
  // controller port
  input  logic                    pad_clr,
  input  logic                    pad_sel,
  input  logic                    six_button,
  input  logic                    multitap,
  output pce_io_pkg::pad_nibble_t pad_data
);

  // loader to store handshake
  logic                  mem_req;
  logic                  mem_ack;
  pce_io_pkg::rom_addr_t mem_addr;
  pce_io_pkg::rom_word_t mem_data;

  // loader to detector
  pce_io_pkg::rom_addr_t load_addr;
  logic                  load_start;
  logic                  word_strobe;

  // scan to nibble select
  pce_io_pkg::pad_port_t port;
  logic                  page_high;
  logic                  clr_active;

  cart_load_fsm u_cart_load_fsm (
    .clk_sys_42_95 (clk_sys_42_95),
    .arst_n        (arst_n),
    .cart_download (cart_download),
    .ioctl_wr      (ioctl_wr),
    .ioctl_dout    (ioctl_dout),
    .bit_reverse   (bit_reverse),
    .ioctl_wait    (ioctl_wait),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .mem_addr      (mem_addr),
    .mem_data      (mem_data),
    .load_addr     (load_addr),
    .load_start    (load_start),
    .word_strobe   (word_strobe)
  );

  // header flag comes straight off the running load address
  populous_detect u_populous_detect (
    .clk_sys_42_95 (clk_sys_42_95),
    .arst_n        (arst_n),
    .load_start    (load_start),
    .word_strobe   (word_strobe),
    .load_addr     (load_addr),
    .word          (mem_data),
    .header_sel    (load_addr[pce_io_pkg::HEADER_BIT]),
    .rom_populous  (rom_populous)
  );

  rom_store u_rom_store (
    .clk_sys_42_95 (clk_sys_42_95),
    .arst_n        (arst_n),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .mem_addr      (mem_addr),
    .mem_data      (mem_data),
    .header_skip   (load_addr[pce_io_pkg::HEADER_BIT]),
    .rom_rd_addr   (rom_rd_addr),
    .rom_rd_data   (rom_rd_data)
  );

  pad_port_scan u_pad_port_scan (
    .clk_sys_42_95 (clk_sys_42_95),
    .arst_n        (arst_n),
    .pad_clr       (pad_clr),
    .pad_sel       (pad_sel),
    .six_button    (six_button),
    .multitap      (multitap),
    .port          (port),
    .page_high     (page_high),
    .clr_active    (clr_active)
  );

  pad_nibble_mux u_pad_nibble_mux (
    .clk_sys_42_95 (clk_sys_42_95),
    .arst_n        (arst_n),
    .button_a      (button_a),
    .button_b      (button_b),
    .button_select (button_select),
    .button_start  (button_start),
    .dpad_up       (dpad_up),
    .dpad_down     (dpad_down),
    .dpad_left     (dpad_left),
    .dpad_right    (dpad_right),
    .port          (port),
    .page_high     (page_high),
    .clr_active    (clr_active),
    .pad_sel       (pad_sel),
    .pad_data      (pad_data)
  );

endmodule

//--- tb_pce_io.sv
`timescale 1ns/1ps

module tb_pce_io;

  localparam int WAIT_LIMIT = 20;
  localparam int PAD_ROWS = 23;

  // signature words at window offsets 6, 8, 10, 12
  localparam pce_io_pkg::rom_word_t SIG_WORDS [4] = '{16'h4F50, 16'h5550, 16'h4F4C, 16'h5355};

  // row layout {clr, sel, six_button, multitap}, buttons, expected nibble
  // buttons {right, left, down, up, start, select, b, a}, 1 = pressed
  localparam logic [15:0] PAD_TABLE [PAD_ROWS] = '{
    16'h0_00_F, 16'h0_01_E, 16'h0_0A_5, 16'h0_F0_F,
    16'h4_00_F, 16'h4_10_E, 16'h4_80_D, 16'h4_60_3,
    16'h4_0F_F, 16'h4_FF_0, 16'h0_FF_0,
    // clear blanks the port
    16'h8_00_0, 16'hC_00_0, 16'h0_05_A,
    // six-button high page, then multitap ports past 0
    16'hB_00_0, 16'h3_00_F, 16'h7_00_0,
    16'hB_00_0, 16'h3_FF_0, 16'h7_FF_F, 16'h3_FF_F, 16'h7_FF_F, 16'h3_FF_F
  };

  logic                    clk_sys_42_95;
  logic                    arst_n;
  logic                    cart_download;
  logic                    ioctl_wr;
  pce_io_pkg::rom_word_t   ioctl_dout;
  logic                    bit_reverse;
  logic                    ioctl_wait;
  pce_io_pkg::rom_addr_t   rom_rd_addr;
  pce_io_pkg::rom_byte_t   rom_rd_data;
  logic                    rom_populous;
  logic                    button_a;
  logic                    button_b;
  logic                    button_select;
  logic                    button_start;
  logic                    dpad_up;
  logic                    dpad_down;
  logic                    dpad_left;
  logic                    dpad_right;
  logic                    pad_clr;
  logic                    pad_sel;
  logic                    six_button;
  logic                    multitap;
  pce_io_pkg::pad_nibble_t pad_data;

  // host side copy of the image being downloaded
  pce_io_pkg::rom_word_t img [8192];
  integer seed;
  int     checks;
  int     errors;
  int     timeouts;
  logic   stalled;

  pce_io_top u_pce_io_top (
    .clk_sys_42_95 (clk_sys_42_95),
    .arst_n        (arst_n),
    .cart_download (cart_download),
    .ioctl_wr      (ioctl_wr),
    .ioctl_dout    (ioctl_dout),
    .bit_reverse   (bit_reverse),
    .ioctl_wait    (ioctl_wait),
    .rom_rd_addr   (rom_rd_addr),
    .rom_rd_data   (rom_rd_data),
    .rom_populous  (rom_populous),
    .button_a      (button_a),
    .button_b      (button_b),
    .button_select (button_select),
    .button_start  (button_start),
    .dpad_up       (dpad_up),
    .dpad_down     (dpad_down),
    .dpad_left     (dpad_left),
    .dpad_right    (dpad_right),
    .pad_clr       (pad_clr),
    .pad_sel       (pad_sel),
    .six_button    (six_button),
    .multitap      (multitap),
    .pad_data      (pad_data)
  );

  initial begin
    clk_sys_42_95 = 1'b0;
    forever #50 clk_sys_42_95 = ~clk_sys_42_95;
  end

  task automatic check_nibble(input string name, input pce_io_pkg::pad_nibble_t exp,
                              input pce_io_pkg::pad_nibble_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input pce_io_pkg::rom_byte_t exp,
                            input pce_io_pkg::rom_byte_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  function automatic pce_io_pkg::rom_byte_t mirror_byte(input pce_io_pkg::rom_byte_t b);
    pce_io_pkg::rom_byte_t r;
    for (int i = 0; i < 8; i++) begin
      r[i] = b[7-i];
    end
    return r;
  endfunction

  // low byte of each word lands on the even address
  function automatic pce_io_pkg::rom_byte_t expected_byte(input int a, input logic rev);
    pce_io_pkg::rom_word_t w;
    pce_io_pkg::rom_byte_t b;
    w = img[a / 2];
    b = a[0] ? w[15:8] : w[7:0];
    if (rev) begin
      b = mirror_byte(b);
    end
    return b;
  endfunction

  task automatic fill_random(input int nwords);
    for (int i = 0; i < nwords; i++) begin
      img[i] = pce_io_pkg::rom_word_t'($random(seed));
    end
  endtask

  // broken copy has one wrong bit in the third word
  task automatic place_signature(input int base, input logic broken);
    for (int k = 0; k < 4; k++) begin
      img[(base + 6 + 2 * k) / 2] = SIG_WORDS[k];
    end
    if (broken) begin
      img[(base + 10) / 2] = SIG_WORDS[2] ^ 16'h0100;
    end
  endtask

  task automatic wait_for_wait(input logic level);
    int n;
    n = 0;
    @(negedge clk_sys_42_95);
    while (ioctl_wait !== level && n < WAIT_LIMIT) begin
      @(negedge clk_sys_42_95);
      n++;
    end
    if (ioctl_wait !== level) begin
      timeouts++;
      stalled = 1'b1;
      $display("ioctl_wait did not go to %b within %0d cycles", level, WAIT_LIMIT);
    end
  endtask

  // hold ioctl_wr until the loader releases ioctl_wait
  task automatic write_word(input pce_io_pkg::rom_word_t w);
    if (!stalled) begin
      @(posedge clk_sys_42_95);
      ioctl_dout <= w;
      ioctl_wr   <= 1'b1;
      wait_for_wait(1'b1);
      wait_for_wait(1'b0);
      @(posedge clk_sys_42_95);
      ioctl_wr <= 1'b0;
      @(posedge clk_sys_42_95);
    end
  endtask

  task automatic load_image(input int nwords, input logic rev);
    @(posedge clk_sys_42_95);
    cart_download <= 1'b1;
    bit_reverse   <= rev;
    repeat (2) @(posedge clk_sys_42_95);
    for (int i = 0; i < nwords; i++) begin
      write_word(img[i]);
    end
    @(posedge clk_sys_42_95);
    cart_download <= 1'b0;
    @(posedge clk_sys_42_95);
  endtask

  // registered read, data one cycle after the address
  task automatic verify_image(input int nbytes, input int offset, input logic rev,
                              input string tag);
    for (int n = 0; n < nbytes; n++) begin
      @(posedge clk_sys_42_95);
      rom_rd_addr <= pce_io_pkg::rom_addr_t'(n);
      @(posedge clk_sys_42_95);
      @(negedge clk_sys_42_95);
      check_byte($sformatf("%s byte %0d", tag, n), expected_byte(n + offset, rev), rom_rd_data);
    end
  endtask

  task automatic check_populous(input string name, input logic exp);
    @(negedge clk_sys_42_95);
    check_flag(name, exp, rom_populous);
  endtask

  // two cycles so a new port number reaches the nibble register
  task automatic apply_pad_row(input logic [15:0] row);
    @(posedge clk_sys_42_95);
    pad_clr    <= row[15];
    pad_sel    <= row[14];
    six_button <= row[13];
    multitap   <= row[12];
    {dpad_right, dpad_left, dpad_down, dpad_up,
     button_start, button_select, button_b, button_a} <= row[11:4];
    repeat (2) @(posedge clk_sys_42_95);
    @(negedge clk_sys_42_95);
  endtask

  initial begin
    seed          = 47;
    checks        = 0;
    errors        = 0;
    timeouts      = 0;
    stalled       = 1'b0;
    arst_n        = 1'b0;
    cart_download = 1'b0;
    ioctl_wr      = 1'b0;
    ioctl_dout    = '0;
    bit_reverse   = 1'b0;
    rom_rd_addr   = '0;
    {dpad_right, dpad_left, dpad_down, dpad_up} = 4'b0000;
    {button_start, button_select, button_b, button_a} = 4'b0000;
    pad_clr       = 1'b0;
    pad_sel       = 1'b0;
    six_button    = 1'b0;
    multitap      = 1'b0;
    repeat (2) @(posedge clk_sys_42_95);
    arst_n <= 1'b1;
    @(posedge clk_sys_42_95);

    // plain image, then the same words bit mirrored
    fill_random(600);
    load_image(600, 1'b0);
    verify_image(1200, 0, 1'b0, "plain");
    load_image(600, 1'b1);
    verify_image(1200, 0, 1'b1, "mirrored");

    // 8 KiB image, final address bit 9 clear
    fill_random(4096);
    place_signature(32'h1F20, 1'b0);
    load_image(4096, 1'b0);
    check_populous("populous plain window", 1'b1);
    place_signature(32'h1F20, 1'b1);
    load_image(4096, 1'b0);
    check_populous("populous plain window broken", 1'b0);

    // headered image ends at 0x2200, bit 9 set
    fill_random(4352);
    place_signature(32'h2120, 1'b0);
    load_image(4352, 1'b0);
    check_populous("populous header window", 1'b1);
    verify_image(32'h2200 - 512, 512, 1'b0, "header skip");

    for (int i = 0; i < PAD_ROWS; i++) begin
      apply_pad_row(PAD_TABLE[i]);
      check_nibble($sformatf("pad row %0d", i), PAD_TABLE[i][3:0], pad_data);
    end

    $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- flist.f
pce_io_pkg.sv
cart_load_fsm.sv
populous_detect.sv
rom_store.sv
pad_port_scan.sv
pad_nibble_mux.sv
pce_io_top.sv
tb_pce_io.sv

//--- Makefile
# Verilator build and run for the PCE I/O testbench

VERILATOR ?= verilator
TOP       ?= tb_pce_io
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter %.sv %.v,$(shell cat $(FLIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
